// ==== files.f ====
gemm_pkg.sv
gemm_csr_file.sv
gemm_mac_lanes.sv
gemm_dot_engine.sv
tcdm_port_gather.sv
gemm_accel_top.sv
tb_tcdm_mem.sv
tb_gemm_accel.sv

// ==== gemm_accel_top.sv ====
// top level of the matrix-vector accelerator
// connects the CSR block, the job sequencer and the TCDM port front end

`timescale 1ns/1ps

module gemm_accel_top import gemm_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      q_valid_i,
  output logic                      q_ready_o,
  input  acc_req_t                  req_i,
  output logic                      p_valid_o,
  input  logic                      p_ready_i,
  output acc_rsp_t                  rsp_o,
  output tcdm_req_t [TcdmPorts-1:0] tcdm_req_o,
  input  tcdm_rsp_t [TcdmPorts-1:0] tcdm_rsp_i,
  output logic                      barrier_o
);

  gemm_cfg_t            cfg;
  logic                 start;
  logic                 busy;
  logic                 rd_req;
  logic [TcdmAddrW-1:0] rd_addr_a;
  logic [TcdmAddrW-1:0] rd_addr_b;
  logic                 rd_done;
  tcdm_word_t           rd_word_a;
  tcdm_word_t           rd_word_b;
  logic                 wr_req;
  logic [TcdmAddrW-1:0] wr_addr;
  tcdm_word_t           wr_data;
  logic                 wr_done;

  gemm_csr_file i_csr_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .q_valid_i (q_valid_i),
    .q_ready_o (q_ready_o),
    .req_i     (req_i),
    .p_valid_o (p_valid_o),
    .p_ready_i (p_ready_i),
    .rsp_o     (rsp_o),
    .busy_i    (busy),
    .cfg_o     (cfg),
    .start_o   (start),
    .barrier_o (barrier_o)
  );

  gemm_dot_engine i_dot_engine (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_i       (cfg),
    .start_i     (start),
    .busy_o      (busy),
    .rd_req_o    (rd_req),
    .rd_addr_a_o (rd_addr_a),
    .rd_addr_b_o (rd_addr_b),
    .rd_done_i   (rd_done),
    .rd_word_a_i (rd_word_a),
    .rd_word_b_i (rd_word_b),
    .wr_req_o    (wr_req),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .wr_done_i   (wr_done)
  );

  tcdm_port_gather i_port_gather (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_done_o   (rd_done),
    .rd_word_a_o (rd_word_a),
    .rd_word_b_o (rd_word_b),
    .wr_req_i    (wr_req),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_done_o   (wr_done),
    .tcdm_req_o  (tcdm_req_o),
    .tcdm_rsp_i  (tcdm_rsp_i)
  );

endmodule

// ==== gemm_csr_file.sv ====
// CSR block of the matrix-vector accelerator
// decodes host requests, holds the job configuration and the cycle counter,
// and returns read data one cycle after acceptance

`timescale 1ns/1ps

module gemm_csr_file import gemm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      q_valid_i,
  output logic      q_ready_o,
  input  acc_req_t  req_i,
  output logic      p_valid_o,
  input  logic      p_ready_i,
  output acc_rsp_t  rsp_o,
  input  logic      busy_i,
  output gemm_cfg_t cfg_o,
  output logic      start_o,
  output logic      barrier_o
);

  csr_word_t          cfg_q [CsrPerf];
  csr_word_t          perf_q;
  csr_word_t          csr_off;
  csr_word_t          rd_data;
  logic [CsrIdxW-1:0] csr_idx;
  logic               in_map;
  logic               accept;
  logic               rd_acc;
  logic               wr_acc;
  logic               p_valid_q;
  acc_rsp_t           rsp_q;

  // ------------------------------------------------------------
  // request decode
  // ------------------------------------------------------------
  assign csr_off = req_i.addr - CsrBase;
  assign csr_idx = csr_off[CsrIdxW-1:0];
  assign in_map  = csr_off < CsrNum;

  // no new request while a read response waits for the host
  assign q_ready_o = !p_valid_q;
  assign accept    = q_valid_i && q_ready_o;
  assign rd_acc    = accept && (req_i.op == csr_read);
  assign wr_acc    = accept && (req_i.op == csr_write);

  // start only from idle, so a second start during a job is dropped
  assign start_o = wr_acc && in_map && (csr_idx == CsrIdxW'(CsrState)) &&
                   req_i.data[0] && !busy_i;

  // configuration registers, perf and state are not stored here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < CsrPerf; i++) begin
        cfg_q[i] <= '0;
      end
    end else if (wr_acc && in_map && (csr_idx < CsrIdxW'(CsrPerf))) begin
      cfg_q[csr_idx] <= req_i.data;
    end
  end

  // busy cycles of the last job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      perf_q <= '0;
    end else if (start_o) begin
      perf_q <= '0;
    end else if (busy_i) begin
      perf_q <= perf_q + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // read path
  // ------------------------------------------------------------
  always_comb begin
    rd_data = '0;
    if (in_map) begin
      if (csr_idx < CsrIdxW'(CsrPerf)) begin
        rd_data = cfg_q[csr_idx];
      end else if (csr_idx == CsrIdxW'(CsrPerf)) begin
        rd_data = perf_q;
      end else if (csr_idx == CsrIdxW'(CsrState)) begin
        // start reads as zero, idle mirrors the engine
        rd_data = {30'b0, !busy_i, 1'b0};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      p_valid_q <= 1'b0;
    end else if (rd_acc) begin
      p_valid_q <= 1'b1;
    end else if (p_ready_i) begin
      p_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rsp_q.data <= rd_data;
      rsp_q.id   <= req_i.id;
    end
  end

  assign p_valid_o = p_valid_q;
  assign rsp_o     = rsp_q;
  assign barrier_o = !busy_i;

  // job configuration fields
  assign cfg_o.m     = cfg_q[CsrSize][15:8];
  assign cfg_o.k     = cfg_q[CsrSize][7:0];
  assign cfg_o.ptr_a = cfg_q[CsrPtrA][TcdmAddrW-1:0];
  assign cfg_o.ptr_b = cfg_q[CsrPtrB][TcdmAddrW-1:0];
  assign cfg_o.ptr_c = cfg_q[CsrPtrC][TcdmAddrW-1:0];
  assign cfg_o.off_a = cfg_q[CsrOffset][7:0];
  assign cfg_o.off_b = cfg_q[CsrOffset][15:8];

endmodule

// ==== gemm_dot_engine.sv ====
// job sequencer of the accelerator
// walks outputs and beats, forms the A, B and C addresses,
// steps the MAC per beat and stores one result word per output

`timescale 1ns/1ps

module gemm_dot_engine import gemm_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  gemm_cfg_t            cfg_i,
  input  logic                 start_i,
  output logic                 busy_o,
  output logic                 rd_req_o,
  output logic [TcdmAddrW-1:0] rd_addr_a_o,
  output logic [TcdmAddrW-1:0] rd_addr_b_o,
  input  logic                 rd_done_i,
  input  tcdm_word_t           rd_word_a_i,
  input  tcdm_word_t           rd_word_b_i,
  output logic                 wr_req_o,
  output logic [TcdmAddrW-1:0] wr_addr_o,
  output tcdm_word_t           wr_data_o,
  input  logic                 wr_done_i
);

  engine_state_e      state_q;
  gemm_cfg_t          job_q;
  logic [SizeW-1:0]   out_q;
  logic [SizeW-1:0]   beat_q;
  // running A word index, equals out*K + beat
  logic [2*SizeW-1:0] a_word_q;
  logic               launch;
  logic               last_beat;
  logic               last_out;
  logic               mac_clear;
  logic               mac_step;
  logic [AccW-1:0]    acc;

  assign launch    = (state_q == st_idle) && start_i;
  assign last_beat = beat_q == job_q.k - 1'b1;
  assign last_out  = out_q == job_q.m - 1'b1;

  // configuration is sampled once so CSR writes mid-job do not disturb it
  always_ff @(posedge clk_i) begin
    if (launch) begin
      job_q <= cfg_i;
    end
  end

  // ------------------------------------------------------------
  // sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= st_idle;
      out_q    <= '0;
      beat_q   <= '0;
      a_word_q <= '0;
    end else begin
      unique case (state_q)
        st_idle: begin
          if (launch && (cfg_i.m != '0)) begin
            out_q    <= '0;
            beat_q   <= '0;
            a_word_q <= '0;
            // K of zero stores plain zeros
            state_q  <= (cfg_i.k == '0) ? st_store : st_fetch;
          end
        end
        st_fetch: begin
          if (rd_done_i) begin
            a_word_q <= a_word_q + 1'b1;
            if (last_beat) begin
              beat_q  <= '0;
              state_q <= st_store;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        st_store: begin
          if (wr_done_i) begin
            if (last_out) begin
              state_q <= st_idle;
            end else begin
              out_q   <= out_q + 1'b1;
              state_q <= (job_q.k == '0) ? st_store : st_fetch;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign busy_o   = state_q != st_idle;
  assign rd_req_o = state_q == st_fetch;
  assign wr_req_o = state_q == st_store;

  // 8-byte words, so indices shift left by three
  assign rd_addr_a_o = job_q.ptr_a + TcdmAddrW'({a_word_q, 3'b000});
  assign rd_addr_b_o = job_q.ptr_b + TcdmAddrW'({beat_q, 3'b000});
  assign wr_addr_o   = job_q.ptr_c + TcdmAddrW'({out_q, 3'b000});

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  assign mac_clear = launch || ((state_q == st_store) && wr_done_i);
  assign mac_step  = (state_q == st_fetch) && rd_done_i;

  gemm_mac_lanes i_mac_lanes (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (mac_clear),
    .step_i   (mac_step),
    .word_a_i (rd_word_a_i),
    .word_b_i (rd_word_b_i),
    .off_a_i  (job_q.off_a),
    .off_b_i  (job_q.off_b),
    .acc_o    (acc)
  );

  assign wr_data_o = {{(TcdmDataW-AccW){acc[AccW-1]}}, acc};

endmodule

// ==== gemm_mac_lanes.sv ====
// eight-lane int8 dot-product step with a 32-bit accumulator
// lanes are offset-corrected to 9 bits before the multiply

`timescale 1ns/1ps

module gemm_mac_lanes import gemm_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             step_i,
  input  tcdm_word_t       word_a_i,
  input  tcdm_word_t       word_b_i,
  input  logic [LaneW-1:0] off_a_i,
  input  logic [LaneW-1:0] off_b_i,
  output logic [AccW-1:0]  acc_o
);

  logic signed [LaneW:0]     diff_a [LaneNum];
  logic signed [LaneW:0]     diff_b [LaneNum];
  logic signed [2*LaneW+1:0] prod   [LaneNum];
  logic signed [AccW-1:0]    beat_sum;
  logic signed [AccW-1:0]    acc_q;

  // lanes and offsets are both signed int8
  always_comb begin
    beat_sum = '0;
    for (int i = 0; i < LaneNum; i++) begin
      diff_a[i] = $signed({word_a_i[i*LaneW+LaneW-1], word_a_i[i*LaneW+:LaneW]}) -
                  $signed({off_a_i[LaneW-1], off_a_i});
      diff_b[i] = $signed({word_b_i[i*LaneW+LaneW-1], word_b_i[i*LaneW+:LaneW]}) -
                  $signed({off_b_i[LaneW-1], off_b_i});
      prod[i]   = diff_a[i] * diff_b[i];
      beat_sum  = beat_sum + prod[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (step_i) begin
      acc_q <= acc_q + beat_sum;
    end
  end

  assign acc_o = acc_q;

endmodule

// ==== gemm_pkg.sv ====
// shared definitions for the CSR-programmed matrix-vector accelerator
// CSR map, TCDM widths, bus structs and the engine state encoding

package gemm_pkg;

  // ------------------------------------------------------------
  // CSR map
  // ------------------------------------------------------------
  localparam int unsigned CsrBase   = 32'h3c0;
  // size holds M in 15:8 and K in 7:0
  localparam int unsigned CsrSize   = 0;
  localparam int unsigned CsrPtrA   = 1;
  localparam int unsigned CsrPtrB   = 2;
  localparam int unsigned CsrPtrC   = 3;
  // offset holds the A offset in 7:0 and the B offset in 15:8
  localparam int unsigned CsrOffset = 4;
  localparam int unsigned CsrPerf   = 5;
  // state bit 0 is start, bit 1 is idle
  localparam int unsigned CsrState  = 6;
  localparam int unsigned CsrNum    = 8;
  localparam int unsigned CsrIdxW   = 3;

  // ------------------------------------------------------------
  // datapath and TCDM widths
  // ------------------------------------------------------------
  localparam int unsigned TcdmDataW  = 64;
  localparam int unsigned TcdmAddrW  = 17;
  localparam int unsigned LaneNum    = 8;
  localparam int unsigned LaneW      = 8;
  localparam int unsigned AccW       = 32;
  localparam int unsigned SizeW      = 8;
  // read port 0 carries A, read port 1 carries B, the write port follows
  localparam int unsigned ReadPorts  = 2;
  localparam int unsigned WritePorts = 1;
  localparam int unsigned TcdmPorts  = ReadPorts + WritePorts;

  typedef logic [TcdmDataW-1:0] tcdm_word_t;
  typedef logic [31:0]          csr_word_t;

  typedef enum logic {
    csr_read  = 1'b0,
    csr_write = 1'b1
  } csr_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_store
  } engine_state_e;

  typedef struct packed {
    csr_op_e     op;
    logic [31:0] addr;
    csr_word_t   data;
    logic [4:0]  id;
  } acc_req_t;

  typedef struct packed {
    csr_word_t  data;
    logic [4:0] id;
  } acc_rsp_t;

  typedef struct packed {
    logic                   q_valid;
    logic [TcdmAddrW-1:0]   addr;
    logic                   write;
    tcdm_word_t             data;
    logic [TcdmDataW/8-1:0] strb;
  } tcdm_req_t;

  typedef struct packed {
    logic       q_ready;
    logic       p_valid;
    tcdm_word_t data;
  } tcdm_rsp_t;

  typedef struct packed {
    logic [SizeW-1:0]     m;
    logic [SizeW-1:0]     k;
    logic [TcdmAddrW-1:0] ptr_a;
    logic [TcdmAddrW-1:0] ptr_b;
    logic [TcdmAddrW-1:0] ptr_c;
    logic [LaneW-1:0]     off_a;
    logic [LaneW-1:0]     off_b;
  } gemm_cfg_t;

endpackage

// ==== tb_gemm_accel.sv ====
// testbench for the matrix-vector accelerator
// programs CSRs over the host port, runs jobs and checks the C words

`timescale 1ns/1ps

module tb_gemm_accel import gemm_pkg::*; ();

  localparam int unsigned ClkHalf     = 50;
  localparam int unsigned ClkPeriod   = 2 * ClkHalf;
  // sum of M*K over the three jobs
  localparam int unsigned JobBeats    = 1 * 1 + 4 * 3 + 4 * 3;
  localparam int unsigned LimitCycles = JobBeats * 40 + 500;

  logic                      clk;
  logic                      rst_n;
  logic                      q_valid;
  logic                      q_ready;
  acc_req_t                  req;
  logic                      p_valid;
  logic                      p_ready;
  acc_rsp_t                  rsp;
  tcdm_req_t [TcdmPorts-1:0] tcdm_req;
  tcdm_rsp_t [TcdmPorts-1:0] tcdm_rsp;
  logic                      barrier;
  int unsigned               wr_count;
  integer                    seed;
  logic [4:0]                req_id;
  int                        mismatch_cnt;
  int                        fail_cnt;

  gemm_accel_top dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .q_valid_i  (q_valid),
    .q_ready_o  (q_ready),
    .req_i      (req),
    .p_valid_o  (p_valid),
    .p_ready_i  (p_ready),
    .rsp_o      (rsp),
    .tcdm_req_o (tcdm_req),
    .tcdm_rsp_i (tcdm_rsp),
    .barrier_o  (barrier)
  );

  tb_tcdm_mem i_mem (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .tcdm_req_i (tcdm_req),
    .tcdm_rsp_o (tcdm_rsp),
    .wr_count_o (wr_count)
  );

  always #(ClkHalf) clk = ~clk;

  // ------------------------------------------------------------
  // checks and reporting
  // ------------------------------------------------------------
  task automatic check_csr(input string name, input csr_word_t exp, input csr_word_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_tcdm(input string name, input tcdm_word_t exp, input tcdm_word_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %016h actual %016h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR %s", msg);
    fail_cnt++;
  endtask

  // ------------------------------------------------------------
  // host port
  // ------------------------------------------------------------
  // returns on the accepting edge
  task automatic wait_accept();
    @(negedge clk);
    while (!q_ready) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic host_write(input int unsigned idx, input csr_word_t data);
    @(posedge clk);
    q_valid <= 1'b1;
    req     <= '{op: csr_write, addr: CsrBase + idx, data: data, id: req_id};
    req_id++;
    wait_accept();
    q_valid <= 1'b0;
  endtask

  task automatic host_read(input csr_word_t addr, input int unsigned stall,
                           output csr_word_t data);
    logic [4:0] id;
    csr_word_t  first;
    logic       held;
    id = req_id;
    req_id++;
    @(posedge clk);
    q_valid <= 1'b1;
    p_ready <= 1'b0;
    req     <= '{op: csr_read, addr: addr, data: '0, id: id};
    wait_accept();
    q_valid <= 1'b0;
    @(negedge clk);
    if (!p_valid || rsp.id !== id) begin
      report_failure("read response missing one cycle after acceptance");
    end
    if (q_ready) begin
      report_failure("host request ready while a read response is pending");
    end
    first = rsp.data;
    held  = 1'b1;
    // the response must hold under host back-pressure
    repeat (stall) begin
      @(negedge clk);
      if (!p_valid || rsp.data !== first || rsp.id !== id) begin
        held = 1'b0;
      end
    end
    @(posedge clk);
    p_ready <= 1'b1;
    @(posedge clk);
    p_ready <= 1'b0;
    @(negedge clk);
    if (p_valid) begin
      report_failure("read response still valid after it completed");
    end
    if (!q_ready) begin
      report_failure("host request not ready after the read response completed");
    end
    if (!held) begin
      report_failure("read response changed while the host stalled");
    end
    data = first;
  endtask

  // ------------------------------------------------------------
  // reference model and jobs
  // ------------------------------------------------------------
  function automatic tcdm_word_t ref_dot(input gemm_cfg_t cfg, input int unsigned j);
    tcdm_word_t wa;
    tcdm_word_t wb;
    byte        la;
    byte        lb;
    byte        oa;
    byte        ob;
    int         acc;
    acc = 0;
    oa  = cfg.off_a;
    ob  = cfg.off_b;
    for (int k = 0; k < cfg.k; k++) begin
      wa = i_mem.mem[(cfg.ptr_a + (j * cfg.k + k) * 8) / 8];
      wb = i_mem.mem[(cfg.ptr_b + k * 8) / 8];
      for (int l = 0; l < 8; l++) begin
        la  = wa[l*8 +: 8];
        lb  = wb[l*8 +: 8];
        acc = acc + (int'(la) - int'(oa)) * (int'(lb) - int'(ob));
      end
    end
    return {{32{acc[31]}}, acc};
  endfunction

  task automatic fill_operands(input gemm_cfg_t cfg);
    for (int w = 0; w < cfg.m * cfg.k; w++) begin
      i_mem.mem[cfg.ptr_a / 8 + w] = {$random(seed), $random(seed)};
    end
    for (int w = 0; w < cfg.k; w++) begin
      i_mem.mem[cfg.ptr_b / 8 + w] = {$random(seed), $random(seed)};
    end
  endtask

  task automatic run_job(input string name, input gemm_cfg_t cfg, input bit restart);
    tcdm_word_t  exp [$];
    int unsigned writes_before;
    csr_word_t   rd;
    for (int j = 0; j < cfg.m; j++) begin
      exp.push_back(ref_dot(cfg, j));
    end
    host_write(CsrSize, {16'h0, cfg.m, cfg.k});
    host_write(CsrPtrA, csr_word_t'(cfg.ptr_a));
    host_write(CsrPtrB, csr_word_t'(cfg.ptr_b));
    host_write(CsrPtrC, csr_word_t'(cfg.ptr_c));
    host_write(CsrOffset, {16'h0, cfg.off_b, cfg.off_a});
    writes_before = wr_count;
    host_write(CsrState, 32'h1);
    @(negedge clk);
    if (barrier) begin
      report_failure({name, ": barrier stayed high after start"});
    end
    if (restart) begin
      host_write(CsrState, 32'h1);
    end
    while (!barrier) @(negedge clk);
    check_csr({name, " write count"}, cfg.m, wr_count - writes_before);
    for (int j = 0; j < cfg.m; j++) begin
      check_tcdm($sformatf("%s c[%0d]", name, j), exp[j],
                 i_mem.mem[(cfg.ptr_c + j * 8) / 8]);
    end
    host_read(CsrBase + CsrState, 0, rd);
    check_csr({name, " state"}, 32'h2, rd);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin : main_seq
    csr_word_t rd;
    csr_word_t wval;
    csr_word_t rnd;
    gemm_cfg_t cfg;
    clk          = 1'b0;
    rst_n        = 1'b0;
    q_valid      = 1'b0;
    p_ready      = 1'b0;
    req          = '0;
    seed         = 53;
    req_id       = '0;
    mismatch_cnt = 0;
    fail_cnt     = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // reset values
    @(negedge clk);
    if (p_valid) begin
      report_failure("p_valid high after reset");
    end
    for (int p = 0; p < TcdmPorts; p++) begin
      if (tcdm_req[p].q_valid) begin
        report_failure($sformatf("TCDM port %0d requests after reset", p));
      end
    end
    if (!barrier) begin
      report_failure("barrier low after reset");
    end
    host_read(CsrBase + CsrState, 0, rd);
    check_csr("reset state", 32'h2, rd);

    // CSR read-back with random host stalls
    for (int i = 0; i <= CsrOffset; i++) begin
      wval = $random(seed);
      rnd  = $random(seed);
      host_write(i, wval);
      host_read(CsrBase + i, rnd % 5, rd);
      check_csr($sformatf("readback csr %0d", i), wval, rd);
    end
    host_read(CsrBase + 32'h40, 2, rd);
    check_csr("unmapped above", 32'h0, rd);
    host_read(32'h0, 1, rd);
    check_csr("unmapped below", 32'h0, rd);

    // jobs
    cfg = '{m: 8'd1, k: 8'd1, ptr_a: 17'h0400, ptr_b: 17'h0800, ptr_c: 17'h0c00,
            off_a: 8'h00, off_b: 8'h00};
    run_job("job m1k1", cfg, 1'b0);

    cfg = '{m: 8'd4, k: 8'd3, ptr_a: 17'h1000, ptr_b: 17'h2000, ptr_c: 17'h3000,
            off_a: 8'h05, off_b: 8'hfd};
    fill_operands(cfg);
    run_job("job m4k3", cfg, 1'b0);

    cfg = '{m: 8'd4, k: 8'd3, ptr_a: 17'h4000, ptr_b: 17'h5000, ptr_c: 17'h6000,
            off_a: 8'hf9, off_b: 8'h11};
    fill_operands(cfg);
    run_job("job restart", cfg, 1'b1);
    host_read(CsrBase + CsrPerf, 1, rd);
    if (rd == 0 || rd < cfg.m * cfg.k) begin
      report_failure($sformatf("perf counter %0d below the %0d beats of the job",
                               rd, cfg.m * cfg.k));
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(LimitCycles * ClkPeriod);
    $display("timeout after %0d cycles, the DUT stopped responding", LimitCycles);
    $display("test failed");
    $finish;
  end

endmodule

// ==== tb_tcdm_mem.sv ====
// TCDM memory model for the accelerator testbench
// grants each port at random and answers reads one cycle after the grant

`timescale 1ns/1ps

module tb_tcdm_mem import gemm_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  tcdm_req_t [TcdmPorts-1:0] tcdm_req_i,
  output tcdm_rsp_t [TcdmPorts-1:0] tcdm_rsp_o,
  output int unsigned               wr_count_o
);

  localparam int unsigned MemWords = 2 ** (TcdmAddrW - 3);

  tcdm_word_t           mem [MemWords];
  integer               seed;
  logic [31:0]          rnd;
  logic [TcdmPorts-1:0] ready_q;
  logic [TcdmPorts-1:0] p_valid_q;
  tcdm_word_t           p_data_q [TcdmPorts];
  tcdm_word_t           wr_word;

  initial begin
    seed = 53;
    for (int i = 0; i < MemWords; i++) begin
      // every field follows the full word index
      mem[i] = {16'ha5c3 ^ 16'(i), 16'(i * 7 + 1), 16'(~i), 16'(i)};
    end
  end

  always_comb begin
    for (int p = 0; p < TcdmPorts; p++) begin
      tcdm_rsp_o[p].q_ready = ready_q[p];
      tcdm_rsp_o[p].p_valid = p_valid_q[p];
      tcdm_rsp_o[p].data    = p_data_q[p];
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q    <= '0;
      p_valid_q  <= '0;
      wr_count_o <= 0;
    end else begin
      rnd = $random(seed);
      ready_q <= rnd[TcdmPorts-1:0];
      for (int p = 0; p < TcdmPorts; p++) begin
        p_valid_q[p] <= 1'b0;
        if (tcdm_req_i[p].q_valid && ready_q[p]) begin
          if (tcdm_req_i[p].write) begin
            // only the enabled byte lanes change
            wr_word = mem[tcdm_req_i[p].addr[TcdmAddrW-1:3]];
            for (int b = 0; b < TcdmDataW / 8; b++) begin
              if (tcdm_req_i[p].strb[b]) begin
                wr_word[b*8 +: 8] = tcdm_req_i[p].data[b*8 +: 8];
              end
            end
            mem[tcdm_req_i[p].addr[TcdmAddrW-1:3]] <= wr_word;
            wr_count_o <= wr_count_o + 1;
          end else begin
            p_valid_q[p] <= 1'b1;
            p_data_q[p]  <= mem[tcdm_req_i[p].addr[TcdmAddrW-1:3]];
          end
        end
      end
    end
  end

endmodule

// ==== tcdm_port_gather.sv ====
// TCDM port front end of the accelerator
// drives the A, B and C ports and holds per-port grants and read data
// until every read port of the beat has answered

`timescale 1ns/1ps

module tcdm_port_gather import gemm_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            rd_req_i,
  input  logic [TcdmAddrW-1:0]            rd_addr_a_i,
  input  logic [TcdmAddrW-1:0]            rd_addr_b_i,
  output logic                            rd_done_o,
  output tcdm_word_t                      rd_word_a_o,
  output tcdm_word_t                      rd_word_b_o,
  input  logic                            wr_req_i,
  input  logic [TcdmAddrW-1:0]            wr_addr_i,
  input  tcdm_word_t                      wr_data_i,
  output logic                            wr_done_o,
  output tcdm_req_t [TcdmPorts-1:0]       tcdm_req_o,
  input  tcdm_rsp_t [TcdmPorts-1:0]       tcdm_rsp_i
);

  logic [TcdmAddrW-1:0] rd_addr [ReadPorts];
  tcdm_word_t           rd_word [ReadPorts];
  tcdm_word_t           data_q  [ReadPorts];
  logic [ReadPorts-1:0] granted_q;
  logic [ReadPorts-1:0] valid_q;
  logic [ReadPorts-1:0] got;

  assign rd_addr[0] = rd_addr_a_i;
  assign rd_addr[1] = rd_addr_b_i;

  // ------------------------------------------------------------
  // request ports
  // ------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < ReadPorts; i++) begin
      // a granted port stays quiet until the beat completes
      tcdm_req_o[i].q_valid = rd_req_i && !granted_q[i];
      tcdm_req_o[i].addr    = rd_addr[i];
      tcdm_req_o[i].write   = 1'b0;
      tcdm_req_o[i].data    = '0;
      tcdm_req_o[i].strb    = '1;
      got[i]     = rd_req_i && (valid_q[i] || tcdm_rsp_i[i].p_valid);
      rd_word[i] = tcdm_rsp_i[i].p_valid ? tcdm_rsp_i[i].data : data_q[i];
    end
    // the write port follows the read ports
    tcdm_req_o[ReadPorts].q_valid = wr_req_i;
    tcdm_req_o[ReadPorts].addr    = wr_addr_i;
    tcdm_req_o[ReadPorts].write   = 1'b1;
    tcdm_req_o[ReadPorts].data    = wr_data_i;
    tcdm_req_o[ReadPorts].strb    = '1;
  end

  assign rd_done_o   = &got;
  assign rd_word_a_o = rd_word[0];
  assign rd_word_b_o = rd_word[1];
  // a write is finished once it is granted
  assign wr_done_o   = wr_req_i && tcdm_rsp_i[ReadPorts].q_ready;

  // ------------------------------------------------------------
  // per-port grant and response capture
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      granted_q <= '0;
      valid_q   <= '0;
    end else if (rd_done_o) begin
      granted_q <= '0;
      valid_q   <= '0;
    end else begin
      for (int i = 0; i < ReadPorts; i++) begin
        if (tcdm_req_o[i].q_valid && tcdm_rsp_i[i].q_ready) begin
          granted_q[i] <= 1'b1;
        end
        if (rd_req_i && tcdm_rsp_i[i].p_valid) begin
          valid_q[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < ReadPorts; i++) begin
      if (tcdm_rsp_i[i].p_valid && !valid_q[i]) begin
        data_q[i] <= tcdm_rsp_i[i].data;
      end
    end
  end

endmodule
